/* run.sh */
#!/usr/bin/env bash
# build and run the fetch stage testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing \
	-f vlog.f \
	--top-module tb_fetch \
	-Mdir "$BUILD_DIR" \
	-o tb_fetch
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$BUILD_DIR/tb_fetch" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

# the log decides
if grep -q "^TESTS PASSED$" "$LOG"; then
	echo "fetch simulation ok"
	exit 0
else
	echo "fetch simulation failed, see $LOG"
	exit 1
fi

/* sim/tb_fetch.sv */
`include "fetch_cfg.svh"

module tb_fetch;

	localparam int NUM_STALLS    = 14;   // control-flow stalls to resolve
	localparam int STALL_TIMEOUT = 1200; // more than one lap of 512 slots
	localparam int WRAP_SLOT     = 500;  // near the end of memory
	localparam logic [63:0] BASE = `FETCH_RESET_PC;

	localparam logic [6:0] OPC_JAL     = 7'h6f;
	localparam logic [6:0] OPC_JALR    = 7'h67;
	localparam logic [6:0] OPC_BRANCH  = 7'h63;
	localparam logic [6:0] OPC_ALU_IMM = 7'h13; // addi and friends

	logic                      clk;
	logic                      rst;
	logic [`FETCH_XLEN-1:0]    dnpc;
	logic                      pc_update;
	logic                      load_en;
	logic [`FETCH_IMEM_AW-1:0] load_addr;
	logic [63:0]               load_data;
	logic [`FETCH_XLEN-1:0]    pc;
	logic [31:0]               inst;
	logic                      valid;

	logic [63:0] shadow [0:`FETCH_IMEM_DEPTH-1]; // copy of the loaded program

	integer seed;
	integer errors;
	integer checks;

	logic [63:0] m_pc;    // model pc
	logic        m_wait;  // model sits in the wait state
	logic        m_known; // model has seen a reset

	fetch_top u_dut (
		.clk       (clk),
		.rst       (rst),
		.dnpc      (dnpc),
		.pc_update (pc_update),
		.load_en   (load_en),
		.load_addr (load_addr),
		.load_data (load_data),
		.pc        (pc),
		.inst      (inst),
		.valid     (valid)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ********************
	// program helpers
	// ********************

	function automatic logic [31:0] alu_filler();
		logic [31:0] w;
		w      = $random(seed);
		w[6:0] = OPC_ALU_IMM; // never control flow
		return w;
	endfunction

	function automatic logic [31:0] encode_word(input logic [6:0] op, input logic [2:0] f3);
		logic [31:0] w;
		w        = $random(seed); // random regs and imm
		w[6:0]   = op;
		w[14:12] = f3;
		return w;
	endfunction

	task automatic put_slot(input int slot, input logic [31:0] w);
		logic [`FETCH_IMEM_AW-1:0] widx;
		widx = `FETCH_IMEM_AW'(slot / 2);
		if (slot % 2 == 1) begin
			shadow[widx][63:32] = w; // odd slot, upper half
		end else begin
			shadow[widx][31:0] = w;
		end
	endtask

	task automatic build_program();
		for (int i = 0; i < `FETCH_IMEM_DEPTH; i++) begin
			shadow[`FETCH_IMEM_AW'(i)] = {alu_filler(), alu_filler()};
		end
		// look-alikes, must flow straight through
		put_slot(3, encode_word(OPC_BRANCH, 3'd2));
		put_slot(4, encode_word(OPC_BRANCH, 3'd3));
		put_slot(5, encode_word(OPC_JALR, 3'd1));
		put_slot(6, encode_word(OPC_JALR, 3'd6));
		// the eight real ones, 4 slots apart
		put_slot(16, encode_word(OPC_JAL, 3'd0));
		put_slot(20, encode_word(OPC_JALR, 3'd0));
		put_slot(24, encode_word(OPC_BRANCH, 3'd0)); // beq
		put_slot(28, encode_word(OPC_BRANCH, 3'd1)); // bne
		put_slot(32, encode_word(OPC_BRANCH, 3'd4)); // blt
		put_slot(36, encode_word(OPC_BRANCH, 3'd5)); // bge
		put_slot(40, encode_word(OPC_BRANCH, 3'd6)); // bltu
		put_slot(44, encode_word(OPC_BRANCH, 3'd7)); // bgeu
	endtask

	// ********************
	// reference model
	// ********************

	function automatic logic is_control_flow(input logic [31:0] w);
		logic [6:0] op;
		logic [2:0] f3;
		op = w[6:0];
		f3 = w[14:12];
		if (op == OPC_JAL) begin
			return 1'b1;
		end else if (op == OPC_JALR) begin
			return f3 == 3'd0;
		end else if (op == OPC_BRANCH) begin
			return (f3 != 3'd2) && (f3 != 3'd3); // 2 and 3 undefined
		end
		return 1'b0;
	endfunction

	// expected outputs now, and model pc and state after the next edge
	function automatic void model_step(
		input  logic [63:0] cur_pc,
		input  logic        cur_wait,
		input  logic        upd,
		input  logic [63:0] tgt,
		output logic [31:0] exp_inst,
		output logic        exp_valid,
		output logic [63:0] nxt_pc,
		output logic        nxt_wait
	);
		logic [63:0] word;
		word     = shadow[cur_pc[`FETCH_IMEM_AW+2:3]]; // wraps with the depth
		exp_inst = cur_pc[2] ? word[63:32] : word[31:0];
		if (!cur_wait) begin
			exp_valid = 1'b1;
			if (is_control_flow(exp_inst)) begin
				nxt_pc   = cur_pc; // park on it
				nxt_wait = 1'b1;
			end else begin
				nxt_pc   = cur_pc + 64'd4;
				nxt_wait = 1'b0;
			end
		end else begin
			exp_valid = 1'b0;
			nxt_pc    = upd ? tgt : cur_pc;
			nxt_wait  = !upd;
		end
	endfunction

	// ********************
	// checker
	// ********************

	initial begin : compare_outputs
		logic [31:0] e_inst;
		logic        e_valid;
		logic [63:0] n_pc;
		logic        n_wait;
		forever begin
			@(negedge clk); // outputs and inputs settled here
			if (m_known && !rst) begin
				model_step(m_pc, m_wait, pc_update, dnpc, e_inst, e_valid, n_pc, n_wait);
				checks = checks + 1;
				if (pc !== m_pc) begin
					$display("[ERROR] pc at %0t: got %h expected %h", $time, pc, m_pc);
					errors = errors + 1;
				end
				if (inst !== e_inst) begin
					$display("[ERROR] inst at %0t: got %h expected %h", $time, inst, e_inst);
					errors = errors + 1;
				end
				if (valid !== e_valid) begin
					$display("[ERROR] valid at %0t: got %h expected %h", $time, valid, e_valid);
					errors = errors + 1;
				end
				m_pc   = n_pc;
				m_wait = n_wait;
			end
			if (rst) begin
				m_pc    = BASE; // next edge resets
				m_wait  = 1'b0;
				m_known = 1'b1;
			end
		end
	end

	// ********************
	// execute stage stand-in
	// ********************

	// returns in the cycle a jump or branch is on show, one edge before the stall
	task automatic wait_for_stall(input int k, output logic ok, output logic [63:0] spc);
		int n;
		n   = 0;
		ok  = 1'b0;
		spc = '0;
		while (!ok && n < STALL_TIMEOUT) begin
			@(negedge clk);
			if (valid === 1'b1 && is_control_flow(inst)) begin
				ok  = 1'b1;
				spc = pc; // pc of the jump or branch about to be held
			end
			n = n + 1;
		end
		if (!ok) begin
			$display("timeout: fetch never presented control flow %0d within %0d cycles",
				k, STALL_TIMEOUT);
			errors = errors + 1;
		end
	endtask

	function automatic logic [63:0] pick_target(input int k, input logic [63:0] spc);
		if (k < 8) begin
			return spc + 64'd4; // fall through, walks all eight
		end
		if (k == 8) begin
			return BASE + 64'(WRAP_SLOT * 4); // runs off the end of memory
		end
		if (k == 12) begin
			return {$random(seed), $random(seed)} & ~64'd3; // far alias
		end
		return BASE + 64'(({$random(seed)} % (`FETCH_IMEM_DEPTH * 2)) * 4);
	endfunction

	initial begin
		int          k;
		int          d;
		logic        ok;
		logic        aborted;
		logic [63:0] spc;
		logic [63:0] tgt;
		seed      = 82;
		errors    = 0;
		checks    = 0;
		m_known   = 1'b0;
		rst       = 1'b0;
		dnpc      = '0;
		pc_update = 1'b0;
		load_en   = 1'b0;
		load_addr = '0;
		load_data = '0;
		build_program();
		// bulk of the program first
		for (int i = 4; i < `FETCH_IMEM_DEPTH; i++) begin
			@(posedge clk);
			load_en   <= 1'b1;
			load_addr <= `FETCH_IMEM_AW'(i);
			load_data <= shadow[`FETCH_IMEM_AW'(i)];
		end
		// 4 reset cycles, first words go in meanwhile
		for (int i = 0; i < 4; i++) begin
			@(posedge clk);
			rst       <= 1'b1;
			load_en   <= 1'b1;
			load_addr <= `FETCH_IMEM_AW'(i);
			load_data <= shadow[`FETCH_IMEM_AW'(i)];
		end
		@(posedge clk);
		rst     <= 1'b0;
		load_en <= 1'b0;
		// stray redirect while issuing
		repeat (8) @(posedge clk);
		pc_update <= 1'b1;
		dnpc      <= {$random(seed), $random(seed)};
		@(posedge clk);
		pc_update <= 1'b0;
		aborted = 1'b0;
		k       = 0;
		while (k < NUM_STALLS && !aborted) begin
			wait_for_stall(k, ok, spc);
			if (!ok) begin
				aborted = 1'b1;
			end else begin
				d   = {$random(seed)} % 7; // wait cycles before pc_update
				tgt = pick_target(k, spc);
				repeat (d) @(posedge clk);
				@(posedge clk);
				pc_update <= 1'b1;
				dnpc      <= tgt;
				@(posedge clk);
				if (k == 2) begin
					// left high into the first issue cycle
					dnpc <= {$random(seed), $random(seed)};
					@(posedge clk);
				end
				pc_update <= 1'b0;
				k = k + 1;
			end
		end
		repeat (30) @(posedge clk);
		if (checks == 0) begin
			$display("no output was ever compared against the model");
			errors = errors + 1;
		end
		$display("%0d cycles compared, %0d stalls resolved, %0d errors", checks, k, errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

/* source/cf_decode.sv */
module cf_decode (
	fetch_if.dec_mp fi
);

	logic [6:0] opcode; // from the field view
	logic [2:0] funct3;
	logic       br_f3_ok; // funct3 names one of the six branches

	assign opcode = fi.inst.f.opcode;
	assign funct3 = fi.inst.f.funct3;

	// ********************
	// branch funct3 check
	// ********************

	// 0 beq, 1 bne, 4 blt, 5 bge, 6 bltu, 7 bgeu
	// 2 and 3 are not defined for the branch opcode
	always_comb begin
		case (funct3)
			3'b000, 3'b001: br_f3_ok = 1'b1;
			3'b100, 3'b101: br_f3_ok = 1'b1;
			3'b110, 3'b111: br_f3_ok = 1'b1;
			default:        br_f3_ok = 1'b0;
		endcase
	end

	// ********************
	// classify
	// ********************

	always_comb begin
		fi.cf_kind = fetch_pkg::cf_none; // plain instruction unless matched
		case (opcode)
			fetch_pkg::OP_JAL: begin
				fi.cf_kind = fetch_pkg::cf_jal; // no funct3 in j-type
			end
			fetch_pkg::OP_JALR: begin
				if (funct3 == 3'b000) begin
					fi.cf_kind = fetch_pkg::cf_jalr;
				end
			end
			fetch_pkg::OP_BRANCH: begin
				if (br_f3_ok) begin
					fi.cf_kind = fetch_pkg::cf_branch;
				end
			end
			default: begin
				fi.cf_kind = fetch_pkg::cf_none;
			end
		endcase
	end

endmodule

/* source/fetch_cfg.svh */
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// ********************
// fetch stage sizing
// ********************

// first pc after reset
`define FETCH_RESET_PC 64'h0000_0000_8000_0000

// pc and dnpc width
`define FETCH_XLEN 64

// 64-bit words in instruction memory
`define FETCH_IMEM_DEPTH 256

// word index width, log2 of depth
`define FETCH_IMEM_AW 8

`endif

/* source/fetch_if.sv */
`include "fetch_cfg.svh"

// signals shared between the fetch blocks
interface fetch_if;

	logic [`FETCH_XLEN-1:0] pc;      // current fetch address
	fetch_pkg::rv_inst_u    inst;    // word at pc
	fetch_pkg::cf_kind_e    cf_kind; // class of inst
	fetch_pkg::pc_sel_e     pc_sel;  // next pc choice

	// pc register
	modport pc_mp (
		output pc,
		input  pc_sel
	);

	// instruction memory read side
	modport mem_mp (
		input  pc,
		output inst
	);

	// control flow classifier
	modport dec_mp (
		input  inst,
		output cf_kind
	);

	// fetch fsm
	modport ctrl_mp (
		input  cf_kind,
		output pc_sel
	);

endinterface

/* source/fetch_pkg.sv */
package fetch_pkg;

	// ********************
	// instruction word
	// ********************

	// common rv32 field split, r-type layout
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode; // bits 6..0
	} rv_fields_s;

	// raw word from memory or the decoded field view
	typedef union packed {
		logic [31:0] raw;
		rv_fields_s  f;
	} rv_inst_u;

	// ********************
	// opcodes
	// ********************

	localparam logic [6:0] OP_JAL    = 7'b110_1111;
	localparam logic [6:0] OP_JALR   = 7'b110_0111;
	localparam logic [6:0] OP_BRANCH = 7'b110_0011; // beq bne blt bge bltu bgeu

	// ********************
	// fetch control types
	// ********************

	// what kind of control flow the current word is
	typedef enum logic [1:0] {
		cf_none   = 2'd0,
		cf_jal    = 2'd1,
		cf_jalr   = 2'd2,
		cf_branch = 2'd3
	} cf_kind_e;

	// next pc source
	typedef enum logic [1:0] {
		pc_seq      = 2'd0, // pc + 4
		pc_hold     = 2'd1, // keep pc
		pc_redirect = 2'd2  // take dnpc from execute
	} pc_sel_e;

endpackage

/* source/fetch_top.sv */
`include "fetch_cfg.svh"

module fetch_top (
	input  logic                      clk,
	input  logic                      rst,
	input  logic [`FETCH_XLEN-1:0]    dnpc,      // redirect target
	input  logic                      pc_update, // redirect strobe
	input  logic                      load_en,   // program write strobe
	input  logic [`FETCH_IMEM_AW-1:0] load_addr,
	input  logic [63:0]               load_data,
	output logic [`FETCH_XLEN-1:0]    pc,
	output logic [31:0]               inst,
	output logic                      valid
);

	// ********************
	// shared fetch signals
	// ********************

	fetch_if fi ();

	// ********************
	// datapath
	// ********************

	// pc register and next pc mux
	pc_unit u_pc_unit (
		.clk  (clk),
		.rst  (rst),
		.dnpc (dnpc),
		.fi   (fi.pc_mp)
	);

	// program store
	imem u_imem (
		.clk       (clk),
		.load_en   (load_en),
		.load_addr (load_addr),
		.load_data (load_data),
		.fi        (fi.mem_mp)
	);

	// jump and branch detect
	cf_decode u_cf_decode (
		.fi (fi.dec_mp)
	);

	// ********************
	// control
	// ********************

	ifu_ctrl u_ifu_ctrl (
		.clk       (clk),
		.rst       (rst),
		.pc_update (pc_update),
		.valid     (valid),
		.fi        (fi.ctrl_mp)
	);

	// ********************
	// outputs
	// ********************

	assign pc   = fi.pc;
	assign inst = fi.inst.raw; // raw view out of the union

endmodule

/* source/ifu_ctrl.sv */
module ifu_ctrl (
	input  logic     clk,
	input  logic     rst,
	input  logic     pc_update, // execute has the next pc on dnpc
	output logic     valid,     // inst at pc goes downstream
	fetch_if.ctrl_mp fi
);

	// issue streams words, wait parks behind control flow
	typedef enum logic {
		st_issue = 1'b0,
		st_wait  = 1'b1
	} state_e;

	state_e state;
	state_e state_next;

	// ********************
	// state register
	// ********************

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_issue;
		end else begin
			state <= state_next;
		end
	end

	// ********************
	// next state and outputs
	// ********************

	always_comb begin
		state_next = state;
		valid      = 1'b0;
		fi.pc_sel  = fetch_pkg::pc_hold; // hold unless told otherwise
		case (state)
			st_issue: begin
				valid = 1'b1; // every word shown once
				if (fi.cf_kind == fetch_pkg::cf_none) begin
					fi.pc_sel = fetch_pkg::pc_seq;
				end else begin
					// jump or branch seen
					// target unknown so park here
					state_next = st_wait;
				end
				// pc_update ignored in this state
			end
			st_wait: begin
				// valid stays low the whole stall
				if (pc_update) begin
					fi.pc_sel  = fetch_pkg::pc_redirect; // dnpc in on this edge
					state_next = st_issue;
				end
			end
			default: begin
				state_next = st_issue;
			end
		endcase
	end

endmodule

/* source/imem.sv */
`include "fetch_cfg.svh"

module imem (
	input  logic                      clk,
	input  logic                      load_en,   // write strobe
	input  logic [`FETCH_IMEM_AW-1:0] load_addr, // word index
	input  logic [63:0]               load_data, // whole 64-bit word
	fetch_if.mem_mp                   fi
);

	// program store, two instructions per word
	logic [63:0] mem [0:`FETCH_IMEM_DEPTH-1];

	logic [`FETCH_IMEM_AW-1:0] rd_idx;  // word picked by pc
	logic [63:0]               rd_word; // raw word before half select

	// ********************
	// load port
	// ********************

	// program goes in while the core sits in reset
	always_ff @(posedge clk) begin
		if (load_en) begin
			mem[load_addr] <= load_data;
		end
	end

	// ********************
	// read port
	// ********************

	// byte address to word index
	// upper pc bits drop out so fetch wraps at the end of memory
	assign rd_idx  = fi.pc[`FETCH_IMEM_AW+2:3];
	assign rd_word = mem[rd_idx]; // async read

	// pc bit 2 picks the 32-bit half
	always_comb begin
		if (fi.pc[2]) begin
			fi.inst.raw = rd_word[63:32]; // odd instruction
		end else begin
			fi.inst.raw = rd_word[31:0];  // even instruction
		end
	end

endmodule

/* source/pc_unit.sv */
`include "fetch_cfg.svh"

module pc_unit (
	input  logic                   clk,
	input  logic                   rst,
	input  logic [`FETCH_XLEN-1:0] dnpc, // resolved target from execute
	fetch_if.pc_mp                 fi
);

	// one instruction is 4 bytes
	localparam logic [`FETCH_XLEN-1:0] PC_STEP = `FETCH_XLEN'(4);

	logic [`FETCH_XLEN-1:0] pc_next; // value loaded on next edge

	// ********************
	// next pc mux
	// ********************

	always_comb begin
		case (fi.pc_sel)
			fetch_pkg::pc_seq: begin
				pc_next = fi.pc + PC_STEP; // straight line
			end
			fetch_pkg::pc_redirect: begin
				pc_next = dnpc; // branch or jump resolved
			end
			fetch_pkg::pc_hold: begin
				pc_next = fi.pc; // stalled on control flow
			end
			default: begin
				pc_next = fi.pc; // unused code holds too
			end
		endcase
	end

	// ********************
	// pc register
	// ********************

	always_ff @(posedge clk) begin
		if (rst) begin
			fi.pc <= `FETCH_RESET_PC;
		end else begin
			fi.pc <= pc_next;
		end
	end

endmodule

/* vlog.f */
+incdir+source
source/fetch_pkg.sv
source/fetch_if.sv
source/pc_unit.sv
source/imem.sv
source/cf_decode.sv
source/ifu_ctrl.sv
source/fetch_top.sv
sim/tb_fetch.sv
